// File: sim/smc_checker.sv
`timescale 1ns/100ps

module smc_checker #(
  parameter int WAIT_STATES = 2
) (
  input  logic             hclk,
  input  logic             reset,
  input  smc_pkg::addr_t   haddr,
  input  smc_pkg::hsize_t  hsize,
  input  logic             smc_valid,
  input  logic             smc_hready,
  input  smc_pkg::hresp_t  smc_hresp,
  input  smc_pkg::data_t   smc_hrdata,
  input  logic             smc_busy,
  input  smc_pkg::addr_t   smc_addr,
  input  smc_pkg::be_n_t   smc_n_be,
  input  logic             smc_n_cs,
  input  logic             smc_n_rd,
  input  logic             smc_n_wr,
  input  smc_pkg::be_n_t   smc_n_we,
  input  logic             smc_n_ext_oe,
  input  logic             exp_valid,    // Data phase of a table entry
  input  logic             exp_write,
  input  smc_pkg::data_t   exp_rdata,
  input  smc_pkg::hresp_t  exp_resp,
  input  logic             drained       // Table done, pipeline empty
);

  int              errors = 0;
  int              entries = 0;
  int              entry_err = 0;
  int              stalls = 0;       // Write data phases held low
  int              cs_len = 0;
  int              stb_len = 0;
  int              first_stb = 0;
  int              oe_len = 0;       // Cycles with write data enabled
  logic            wr_acc = 1'b0;    // Access had a write strobe
  logic            prev_cs = 1'b1;
  logic            prev_ready = 1'b1;
  smc_pkg::hresp_t prev_resp = smc_pkg::HRESP_OKAY;
  logic            drain_fail = 1'b0;
  smc_pkg::addr_t  req_addr [$];     // Accepted legal transfers, in order
  smc_pkg::hsize_t req_size [$];

  // Lanes inside the addressed byte, halfword or word are enabled
  function automatic smc_pkg::be_n_t lanes_for(smc_pkg::addr_t a, smc_pkg::hsize_t s);
    smc_pkg::be_n_t be_n;
    be_n = 4'hF;
    for (int l = 0; l < 4; l++)
      if ((l >> s) == (a[1:0] >> s))
        be_n[l] = 1'b0;
    return be_n;
  endfunction

  task automatic fail_hex(string sig, logic [31:0] got, logic [31:0] exp);
    $display("[ERROR] entry %0d %s got %h expected %h", entries, sig, got, exp);
    errors++;
    entry_err++;
  endtask

  task automatic fail_text(string msg);
    $display("entry %0d: %s", entries, msg);
    errors++;
    entry_err++;
  endtask

  // --------------------------------------------------------------------------
  // Sampling on the falling edge, away from register updates
  // --------------------------------------------------------------------------
  always @(negedge hclk) begin
    if (reset) begin
      if (smc_n_cs !== 1'b1) fail_hex("smc_n_cs", smc_n_cs, 1);
      if (smc_n_rd !== 1'b1) fail_hex("smc_n_rd", smc_n_rd, 1);
      if (smc_n_wr !== 1'b1) fail_hex("smc_n_wr", smc_n_wr, 1);
      if (smc_n_we !== 4'hF) fail_hex("smc_n_we", smc_n_we, 4'hF);
      if (smc_n_ext_oe !== 1'b1) fail_hex("smc_n_ext_oe", smc_n_ext_oe, 1);
      if (smc_valid !== 1'b0) fail_hex("smc_valid", smc_valid, 0);
      if (smc_busy !== 1'b0) fail_hex("smc_busy", smc_busy, 0);
      if (smc_hready !== 1'b1) fail_hex("smc_hready", smc_hready, 1);
      if (smc_hresp !== smc_pkg::HRESP_OKAY) fail_hex("smc_hresp", smc_hresp, 0);
    end else begin
      if (smc_valid) begin
        req_addr.push_back(haddr);
        req_size.push_back(hsize);
      end
      // Access start, compare address and lanes with the oldest request
      if (!smc_n_cs && prev_cs) begin
        if (req_addr.size() == 0) begin
          fail_text("EMI access started with no accepted transfer");
        end else begin
          if (smc_addr !== req_addr[0]) fail_hex("smc_addr", smc_addr, req_addr[0]);
          if (smc_n_be !== lanes_for(req_addr[0], req_size[0]))
            fail_hex("smc_n_be", smc_n_be, lanes_for(req_addr[0], req_size[0]));
          void'(req_addr.pop_front());
          void'(req_size.pop_front());
        end
      end
      // Setup, strobe, hold framing
      if (!smc_n_cs) begin
        cs_len++;
        if (!smc_n_ext_oe) oe_len++;
        if (!smc_n_wr) wr_acc = 1'b1;
        if (!smc_n_rd || !smc_n_wr) begin
          if (stb_len == 0) first_stb = cs_len;
          stb_len++;
        end
      end else begin
        if (smc_n_ext_oe !== 1'b1) fail_hex("smc_n_ext_oe", smc_n_ext_oe, 1);
        if (!prev_cs) begin
          if (cs_len != WAIT_STATES + 3 || stb_len != WAIT_STATES + 1 || first_stb != 2)
            fail_text($sformatf("bad EMI timing, cs low %0d strobe %0d from cycle %0d",
                                cs_len, stb_len, first_stb));
          // Write data driven for the whole access, never on reads
          if (oe_len != (wr_acc ? cs_len : 0))
            fail_text($sformatf("write data enable low %0d of %0d access cycles",
                                oe_len, cs_len));
          cs_len  = 0;
          stb_len = 0;
          oe_len  = 0;
          wr_acc  = 1'b0;
        end
      end
      if (exp_valid && exp_write && !smc_hready && exp_resp == smc_pkg::HRESP_OKAY)
        stalls++;
      // Data phase completes
      if (exp_valid && smc_hready) begin
        if (smc_hresp !== exp_resp) fail_hex("smc_hresp", smc_hresp, exp_resp);
        if (exp_resp == smc_pkg::HRESP_ERROR &&
            (prev_ready || prev_resp != smc_pkg::HRESP_ERROR))
          fail_text("ERROR response missing its first stalled cycle");
        if (!exp_write && exp_resp == smc_pkg::HRESP_OKAY && smc_hrdata !== exp_rdata)
          fail_hex("smc_hrdata", smc_hrdata, exp_rdata);
        $display("entry %0d %s %s", entries, exp_write ? "write" : "read ",
                 entry_err == 0 ? "ok" : "FAILED");
        entries++;
        entry_err = 0;
      end
      if (drained && !drain_fail && (smc_busy || !smc_n_cs || req_addr.size() != 0)) begin
        fail_text("controller still busy after all transfers finished");
        drain_fail = 1'b1;
      end
    end
    prev_cs    = smc_n_cs;
    prev_ready = smc_hready;
    prev_resp  = smc_hresp;
  end

  task automatic print_counts();
    if (stalls == 0) begin
      $display("posted writes never saw hready held low");
      errors++;
    end
    $display("entries %0d, stalled write cycles %0d, errors %0d", entries, stalls, errors);
  endtask

endmodule

// File: sim/smc_sram_model.sv
`timescale 1ns/100ps

// Async SRAM, 256 words, byte-lane writes while the write strobe is low
module smc_sram_model (
  input  logic           hclk,
  input  smc_pkg::addr_t smc_addr,
  input  smc_pkg::data_t smc_data,
  input  logic           smc_n_cs,
  input  logic           smc_n_rd,
  input  logic           smc_n_wr,
  input  smc_pkg::be_n_t smc_n_we,
  output smc_pkg::data_t data_smc
);

  smc_pkg::data_t mem [256];
  logic [7:0]     idx;

  assign idx = smc_addr[9:2]; // Word index

  initial begin
    for (int i = 0; i < 256; i++)
      mem[i] = {8'h5A, 8'(i), ~8'(i), 8'(i)}; // Fill follows the word index
  end

  always @(posedge hclk) begin
    if (!smc_n_cs && !smc_n_wr) begin
      for (int l = 0; l < 4; l++)
        if (!smc_n_we[l])
          mem[idx][8*l +: 8] <= smc_data[8*l +: 8];
    end
  end

  assign data_smc = (!smc_n_cs && !smc_n_rd) ? mem[idx] : '0;

endmodule

// File: sim/smc_veneer_tb.sv
`timescale 1ns/100ps

module smc_veneer_tb;

  localparam int WAIT_STATES = 2;
  localparam int RESET_CYCLES = 5;

  typedef struct {
    logic            write;
    smc_pkg::addr_t  addr;
    smc_pkg::hsize_t size;
    smc_pkg::data_t  wdata;
    smc_pkg::data_t  rdata;  // Expected on reads
    smc_pkg::hresp_t resp;
    logic            b2b;    // No idle gap before this entry
  } entry_t;

  logic             hclk = 1'b0;
  logic             reset = 1'b1;
  smc_pkg::addr_t   haddr = '0;
  smc_pkg::htrans_t htrans = smc_pkg::HTRANS_IDLE;
  logic             hsel = 1'b0;
  logic             hwrite = 1'b0;
  smc_pkg::hsize_t  hsize = '0;
  smc_pkg::data_t   hwdata = '0;
  logic             hready;
  smc_pkg::data_t   smc_hrdata, smc_data, data_smc;
  logic             smc_hready, smc_valid, smc_busy;
  smc_pkg::hresp_t  smc_hresp;
  smc_pkg::addr_t   smc_addr;
  smc_pkg::be_n_t   smc_n_be, smc_n_we;
  logic             smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe;
  logic             exp_valid = 1'b0;
  logic             exp_write = 1'b0;
  smc_pkg::data_t   exp_rdata = '0;
  smc_pkg::hresp_t  exp_resp = smc_pkg::HRESP_OKAY;
  logic             drained = 1'b0;
  entry_t           table_q [$];
  int               cycles = 0;
  int               limit;

  assign hready = smc_hready; // Single slave on the bus

  always #5 hclk = ~hclk;

  smc_veneer #(.WAIT_STATES(WAIT_STATES), .REQ_CREDITS(2)) dut_i (.*);

  smc_sram_model sram_i (.*);

  smc_checker #(.WAIT_STATES(WAIT_STATES)) chk_i (.*);

  task automatic add(logic w, smc_pkg::addr_t a, smc_pkg::hsize_t s, smc_pkg::data_t wd,
                     smc_pkg::data_t rd, smc_pkg::hresp_t r, logic b);
    entry_t e;
    e = '{w, a, s, wd, rd, r, b};
    table_q.push_back(e);
  endtask

  // --------------------------------------------------------------------------
  // Stimulus table
  // --------------------------------------------------------------------------
  task automatic build_table();
    add(1, 32'h10, 3'd2, 32'h11223344, 0, smc_pkg::HRESP_OKAY, 0);
    add(0, 32'h10, 3'd2, 0, 32'h11223344, smc_pkg::HRESP_OKAY, 0);
    // Bytes at each offset
    add(1, 32'h20, 3'd2, 32'hAABBCCDD, 0, smc_pkg::HRESP_OKAY, 0);
    add(1, 32'h20, 3'd0, 32'h000000EE, 0, smc_pkg::HRESP_OKAY, 0);
    add(1, 32'h23, 3'd0, 32'h77000000, 0, smc_pkg::HRESP_OKAY, 0);
    add(1, 32'h21, 3'd0, 32'h00005500, 0, smc_pkg::HRESP_OKAY, 0);
    add(0, 32'h20, 3'd2, 0, 32'h77BB55EE, smc_pkg::HRESP_OKAY, 0);
    // Halfwords and the remaining byte offset
    add(1, 32'h30, 3'd2, 32'h01234567, 0, smc_pkg::HRESP_OKAY, 0);
    add(1, 32'h30, 3'd1, 32'h0000BEEF, 0, smc_pkg::HRESP_OKAY, 0);
    add(1, 32'h32, 3'd1, 32'hCAFE0000, 0, smc_pkg::HRESP_OKAY, 0);
    add(1, 32'h32, 3'd0, 32'h00990000, 0, smc_pkg::HRESP_OKAY, 0);
    add(0, 32'h30, 3'd2, 0, 32'hCA99BEEF, smc_pkg::HRESP_OKAY, 0);
    // Posted writes past the credit count
    for (int k = 0; k < 6; k++)
      add(1, 32'h40 + 4 * k, 3'd2, 32'hB0000000 + k, 0, smc_pkg::HRESP_OKAY, 1);
    add(0, 32'h54, 3'd2, 0, 32'hB0000005, smc_pkg::HRESP_OKAY, 1);
    add(0, 32'h40, 3'd2, 0, 32'hB0000000, smc_pkg::HRESP_OKAY, 0);
    // Illegal sizes and alignments
    add(1, 32'h61, 3'd2, 32'hDEADDEAD, 0, smc_pkg::HRESP_ERROR, 0);
    add(0, 32'h63, 3'd1, 0, 0, smc_pkg::HRESP_ERROR, 0);
    add(0, 32'h60, 3'd3, 0, 0, smc_pkg::HRESP_ERROR, 0);
  endtask

  // One AHB transfer, address phase then data phase until ready
  task automatic run_entry(entry_t e);
    htrans <= smc_pkg::HTRANS_NONSEQ;
    hsel   <= 1'b1;
    hwrite <= e.write;
    haddr  <= e.addr;
    hsize  <= e.size;
    @(posedge hclk);
    htrans    <= smc_pkg::HTRANS_IDLE;
    hsel      <= 1'b0;
    hwdata    <= e.wdata;
    exp_valid <= 1'b1;
    exp_write <= e.write;
    exp_rdata <= e.rdata;
    exp_resp  <= e.resp;
    do
      @(negedge hclk);
    while (!smc_hready);
    @(posedge hclk);
    exp_valid <= 1'b0;
  endtask

  // Run limit scales with the table length
  always @(posedge hclk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: transfers did not finish within %0d cycles", limit);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(34937));
    limit = 0;
    build_table();
    limit = table_q.size() * (WAIT_STATES + 3) * 4 + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge hclk);
    reset <= 1'b0;
    @(posedge hclk);
    foreach (table_q[i]) begin
      if (!table_q[i].b2b)
        repeat ($urandom % 4) @(posedge hclk); // Idle gap
      run_entry(table_q[i]);
    end
    do
      @(negedge hclk);
    while (smc_busy);
    @(posedge hclk);
    drained <= 1'b1;
    repeat (3) @(posedge hclk);
    chk_i.print_counts();
    if (chk_i.errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// File: smc_veneer.f
source/smc_pkg.sv
source/smc_req_if.sv
source/smc_ahb_slave.sv
source/smc_lane_map.sv
source/smc_access_fsm.sv
source/smc_veneer.sv
sim/smc_sram_model.sv
sim/smc_checker.sv
sim/smc_veneer_tb.sv

// File: source/smc_access_fsm.sv
`timescale 1ns/100ps

module smc_access_fsm #(
  parameter int WAIT_STATES = 2
) (
  input  logic           hclk,
  input  logic           reset,
  smc_req_if.dst         req,          // From lane mapper
  input  smc_pkg::data_t data_smc,     // EMI read data
  output smc_pkg::addr_t smc_addr,
  output smc_pkg::data_t smc_data,
  output smc_pkg::be_n_t smc_n_be,
  output logic           smc_n_cs,
  output logic           smc_n_rd,
  output logic           smc_n_wr,
  output logic           smc_n_ext_oe,
  output smc_pkg::be_n_t smc_n_we,
  output logic           rdata_valid,
  output smc_pkg::data_t rdata,
  output logic           active
);

  localparam int WAIT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  smc_pkg::access_state_t state, next_state;
  logic [WAIT_W-1:0]      wait_cnt;    // Strobe cycles left
  logic                   acc_write;
  smc_pkg::be_n_t         acc_be_n;
  logic                   strobe;
  logic                   last_strobe;

  // --------------------------------------------------------------------------
  // Access timing
  // --------------------------------------------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      smc_pkg::IDLE:   if (req.valid) next_state = smc_pkg::SETUP;
      smc_pkg::SETUP:  next_state = smc_pkg::STROBE;
      smc_pkg::STROBE: if (last_strobe) next_state = smc_pkg::HOLD;
      smc_pkg::HOLD:   next_state = smc_pkg::IDLE;
      default:         next_state = smc_pkg::IDLE;
    endcase
  end

  always_ff @(posedge hclk) begin
    if (reset) begin
      state    <= smc_pkg::IDLE;
      wait_cnt <= '0;
    end else begin
      state <= next_state;
      if (state == smc_pkg::SETUP)
        wait_cnt <= WAIT_W'(WAIT_STATES); // Strobe is WAIT_STATES+1 long
      else if (strobe && !last_strobe)
        wait_cnt <= wait_cnt - 1'b1;
    end
  end

  assign strobe      = (state == smc_pkg::STROBE);
  assign last_strobe = strobe && (wait_cnt == '0);

  // Request capture and read sampling
  always_ff @(posedge hclk) begin
    if (state == smc_pkg::IDLE && req.valid) begin
      acc_write <= req.write;
      acc_be_n  <= req.be_n;
      smc_addr  <= req.addr;
      smc_data  <= req.wdata;
    end
    if (last_strobe && !acc_write)
      rdata <= data_smc; // Last strobe cycle
  end

  // --------------------------------------------------------------------------
  // EMI outputs
  // --------------------------------------------------------------------------
  assign smc_n_cs     = (state == smc_pkg::IDLE);
  assign smc_n_be     = smc_n_cs ? 4'hF : acc_be_n;
  assign smc_n_rd     = !(strobe && !acc_write);
  assign smc_n_wr     = !(strobe && acc_write);
  assign smc_n_we     = (strobe && acc_write) ? acc_be_n : 4'hF; // Per-lane strobes
  assign smc_n_ext_oe = !(acc_write && !smc_n_cs); // Drive data SETUP to HOLD

  assign rdata_valid = (state == smc_pkg::HOLD) && !acc_write;
  assign req.credit  = (state == smc_pkg::HOLD);  // Free for next request
  assign active      = !smc_n_cs;

  // Mapper only sends with the single credit in hand
  a_req_when_idle: assert property (@(posedge hclk) disable iff (reset)
    req.valid |-> state == smc_pkg::IDLE);

endmodule

// File: source/smc_ahb_slave.sv
`timescale 1ns/100ps

module smc_ahb_slave #(
  parameter int REQ_CREDITS = 2
) (
  input  logic             hclk,
  input  logic             reset,
  input  logic             hsel,
  input  logic             hready,      // Muxed bus ready
  input  logic             hwrite,
  input  smc_pkg::addr_t   haddr,
  input  smc_pkg::htrans_t htrans,
  input  smc_pkg::hsize_t  hsize,
  input  smc_pkg::data_t   hwdata,
  smc_req_if.src           req,         // To lane mapper
  input  logic             rdata_valid,
  input  smc_pkg::data_t   rdata,
  output logic             smc_hready,
  output logic             smc_valid,
  output smc_pkg::hresp_t  smc_hresp,
  output smc_pkg::data_t   smc_hrdata,
  output logic             pending
);

  localparam int CRED_W = $clog2(REQ_CREDITS + 1);

  // Data phase state
  typedef enum logic [2:0] {OKAY, WAIT_CREDIT, WAIT_READ, ERR1, ERR2} dphase_t;

  dphase_t           state, next_state, phase_state;
  logic              transfer, accept, legal;
  smc_pkg::addr_t    ap_addr;     // Registered address phase
  smc_pkg::hsize_t   ap_size;
  logic [CRED_W-1:0] credits;
  logic              has_credit;
  logic              rd_issued;   // Read request sent downstream
  logic              rd_done;     // Read data back, release bus

  // --------------------------------------------------------------------------
  // Address phase decode
  // --------------------------------------------------------------------------
  always_comb begin
    case (htrans)
      smc_pkg::HTRANS_NONSEQ, smc_pkg::HTRANS_SEQ: transfer = 1'b1;
      smc_pkg::HTRANS_IDLE, smc_pkg::HTRANS_BUSY:  transfer = 1'b0;
    endcase
  end

  always_comb begin
    case (hsize)
      3'b000:  legal = 1'b1;                  // Byte
      3'b001:  legal = ~haddr[0];             // Halfword
      3'b010:  legal = (haddr[1:0] == 2'b00); // Word
      default: legal = 1'b0;                  // Wider than the bus
    endcase
  end

  assign accept    = hsel && hready && transfer;
  assign smc_valid = accept && legal;

  // Where the next data phase starts
  always_comb begin
    if (!accept)
      phase_state = OKAY;
    else if (!legal)
      phase_state = ERR1;
    else if (hwrite)
      phase_state = WAIT_CREDIT;
    else
      phase_state = WAIT_READ;
  end

  // --------------------------------------------------------------------------
  // Data phase
  // --------------------------------------------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      OKAY:        next_state = phase_state;
      WAIT_CREDIT: if (has_credit) next_state = phase_state; // Write posted
      WAIT_READ:   if (rd_done) next_state = phase_state;
      ERR1:        next_state = ERR2;
      ERR2:        next_state = phase_state;
      default:     next_state = OKAY;
    endcase
  end

  always_ff @(posedge hclk) begin
    if (reset) begin
      state     <= OKAY;
      credits   <= CRED_W'(REQ_CREDITS); // Receiver buffer depth
      rd_issued <= 1'b0;
      rd_done   <= 1'b0;
    end else begin
      state   <= next_state;
      credits <= credits - CRED_W'(req.valid) + CRED_W'(req.credit);
      if (state == WAIT_READ && rd_done) begin
        rd_issued <= 1'b0;
        rd_done   <= 1'b0;
      end else begin
        if (req.valid && !req.write)
          rd_issued <= 1'b1;
        if (rdata_valid)
          rd_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge hclk) begin
    if (accept) begin
      ap_addr <= haddr;
      ap_size <= hsize;
    end
    if (rdata_valid)
      smc_hrdata <= rdata; // Held until the next read
  end

  always_comb begin
    smc_hready = 1'b1;
    smc_hresp  = smc_pkg::HRESP_OKAY;
    case (state)
      WAIT_CREDIT: smc_hready = has_credit;
      WAIT_READ:   smc_hready = rd_done;
      ERR1: begin
        smc_hready = 1'b0; // First ERROR cycle
        smc_hresp  = smc_pkg::HRESP_ERROR;
      end
      ERR2:        smc_hresp = smc_pkg::HRESP_ERROR;
      default:     smc_hready = 1'b1;
    endcase
  end

  // Request toward the lane mapper
  assign has_credit = (credits != '0);
  assign req.valid  = has_credit &&
                      ((state == WAIT_CREDIT) || (state == WAIT_READ && !rd_issued));
  assign req.write  = (state == WAIT_CREDIT);
  assign req.addr   = ap_addr;
  assign req.size   = ap_size;
  assign req.wdata  = hwdata; // Valid in the write data phase
  assign req.be_n   = '1;     // Mapper computes lanes
  assign pending    = (state == WAIT_CREDIT) || (state == WAIT_READ);

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Spending at zero or a spurious returned credit pushes the count past the depth
  a_credit_bound: assert property (@(posedge hclk) disable iff (reset)
    credits <= CRED_W'(REQ_CREDITS));

  // ERROR is always one stall cycle then one ready cycle
  a_err_second: assert property (@(posedge hclk) disable iff (reset)
    (smc_hresp == smc_pkg::HRESP_ERROR && !smc_hready)
      |=> (smc_hresp == smc_pkg::HRESP_ERROR && smc_hready));
  a_err_first: assert property (@(posedge hclk) disable iff (reset)
    (smc_hresp == smc_pkg::HRESP_ERROR && smc_hready)
      |-> $past(smc_hresp == smc_pkg::HRESP_ERROR && !smc_hready));

endmodule

// File: source/smc_lane_map.sv
`timescale 1ns/100ps

module smc_lane_map #(
  parameter int REQ_CREDITS = 2
) (
  input  logic   hclk,
  input  logic   reset,
  smc_req_if.dst up,       // From AHB front end
  smc_req_if.src down,     // To access sequencer
  output logic   occupied  // Buffer not empty
);

  localparam int PTR_W = (REQ_CREDITS > 1) ? $clog2(REQ_CREDITS) : 1;
  localparam int CNT_W = $clog2(REQ_CREDITS + 1);

  // Request store, payload only
  logic            buf_write [REQ_CREDITS];
  smc_pkg::addr_t  buf_addr  [REQ_CREDITS];
  smc_pkg::hsize_t buf_size  [REQ_CREDITS];
  smc_pkg::data_t  buf_wdata [REQ_CREDITS];

  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic             down_credit; // Sequencer holds one request
  smc_pkg::addr_t   head_addr;
  smc_pkg::hsize_t  head_size;
  smc_pkg::data_t   head_wdata;
  logic [1:0]       lane;

  always_ff @(posedge hclk) begin
    if (up.valid) begin
      buf_write[wr_ptr] <= up.write;
      buf_addr[wr_ptr]  <= up.addr;
      buf_size[wr_ptr]  <= up.size;
      buf_wdata[wr_ptr] <= up.wdata;
    end
  end

  // --------------------------------------------------------------------------
  // Pointers and credits
  // --------------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (reset) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      down_credit <= 1'b1;
    end else begin
      if (up.valid)
        wr_ptr <= (wr_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      if (down.valid)
        rd_ptr <= (rd_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(up.valid) - CNT_W'(down.valid);
      if (down.valid)
        down_credit <= 1'b0;
      if (down.credit)
        down_credit <= 1'b1; // Sequencer left HOLD
    end
  end

  assign occupied   = (count != '0);
  assign down.valid = occupied && down_credit;
  assign up.credit  = down.valid; // Slot freed as head leaves

  assign head_addr  = buf_addr[rd_ptr];
  assign head_size  = buf_size[rd_ptr];
  assign head_wdata = buf_wdata[rd_ptr];
  assign lane       = head_addr[1:0];

  assign down.write = buf_write[rd_ptr];
  assign down.addr  = head_addr;
  assign down.size  = head_size;

  // Lane enables and replicated write data
  always_comb begin
    case (head_size)
      3'b000: begin
        down.be_n  = ~(4'b0001 << lane);
        down.wdata = {4{head_wdata[8*lane +: 8]}};
      end
      3'b001: begin
        down.be_n  = lane[1] ? 4'b0011 : 4'b1100; // Upper or lower half
        down.wdata = {2{head_wdata[16*lane[1] +: 16]}};
      end
      default: begin
        down.be_n  = 4'b0000;
        down.wdata = head_wdata;
      end
    endcase
  end

  // Front end credit count must keep this from happening
  a_no_overflow: assert property (@(posedge hclk) disable iff (reset)
    up.valid |-> count != CNT_W'(REQ_CREDITS));

endmodule

// File: source/smc_pkg.sv
package smc_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  typedef logic [31:0] addr_t;   // Byte address
  typedef logic [31:0] data_t;   // Bus data word
  typedef logic [3:0]  be_n_t;   // Byte enables, active low, bit 0 is lane 0
  typedef logic [2:0]  hsize_t;  // AHB size code
  typedef logic [1:0]  htrans_t; // AHB transfer type
  typedef logic [1:0]  hresp_t;  // AHB response

  // AHB transfer types
  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_BUSY   = 2'b01;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;
  localparam htrans_t HTRANS_SEQ    = 2'b11;

  // AHB responses, RETRY and SPLIT never issued
  localparam hresp_t HRESP_OKAY  = 2'b00;
  localparam hresp_t HRESP_ERROR = 2'b01;

  // External memory access phases
  typedef enum logic [1:0] {
    IDLE,   // Chip select high
    SETUP,  // Address and enables out
    STROBE, // Read or write strobe low
    HOLD    // Strobes released, cs still low
  } access_state_t;

endpackage

// File: source/smc_req_if.sv
`timescale 1ns/100ps

// One request per valid pulse, credit flows back
interface smc_req_if;

  logic            valid;  // Single-cycle request strobe
  logic            write;  // 1 write, 0 read
  smc_pkg::addr_t  addr;   // Byte address
  smc_pkg::hsize_t size;   // AHB size code
  smc_pkg::data_t  wdata;  // Write data
  smc_pkg::be_n_t  be_n;   // Lane enables, active low
  logic            credit; // Receiver freed a slot

  // Sending side
  modport src (
    output valid, write, addr, size, wdata, be_n,
    input  credit
  );

  // Receiving side
  modport dst (
    input  valid, write, addr, size, wdata, be_n,
    output credit
  );

endinterface

// File: source/smc_veneer.sv
`timescale 1ns/100ps

// Static memory controller, AHB-lite in, async SRAM out
module smc_veneer #(
  parameter int WAIT_STATES = 2,
  parameter int REQ_CREDITS = 2
) (
  input  logic             hclk,
  input  logic             reset,
  // AHB
  input  smc_pkg::addr_t   haddr,
  input  smc_pkg::htrans_t htrans,
  input  logic             hsel,
  input  logic             hwrite,
  input  smc_pkg::hsize_t  hsize,
  input  smc_pkg::data_t   hwdata,
  input  logic             hready,
  output smc_pkg::data_t   smc_hrdata,
  output logic             smc_hready,
  output smc_pkg::hresp_t  smc_hresp,
  output logic             smc_valid,     // Legal address accepted
  // EMI
  input  smc_pkg::data_t   data_smc,
  output smc_pkg::addr_t   smc_addr,
  output smc_pkg::data_t   smc_data,
  output smc_pkg::be_n_t   smc_n_be,
  output logic             smc_n_cs,
  output smc_pkg::be_n_t   smc_n_we,
  output logic             smc_n_wr,
  output logic             smc_n_rd,
  output logic             smc_n_ext_oe,  // Write data pad enable
  output logic             smc_busy
);

  logic           pending, occupied, active;
  logic           rdata_valid;
  smc_pkg::data_t rdata;

  smc_req_if req_a ();  // Front end to mapper
  smc_req_if req_b ();  // Mapper to sequencer

  // --------------------------------------------------------------------------
  // Pipeline stages
  // --------------------------------------------------------------------------
  smc_ahb_slave #(
    .REQ_CREDITS (REQ_CREDITS)
  ) ahb_slave_i (
    .hclk        (hclk),
    .reset       (reset),
    .hsel        (hsel),
    .hready      (hready),
    .hwrite      (hwrite),
    .haddr       (haddr),
    .htrans      (htrans),
    .hsize       (hsize),
    .hwdata      (hwdata),
    .req         (req_a.src),
    .rdata_valid (rdata_valid),
    .rdata       (rdata),
    .smc_hready  (smc_hready),
    .smc_valid   (smc_valid),
    .smc_hresp   (smc_hresp),
    .smc_hrdata  (smc_hrdata),
    .pending     (pending)
  );

  smc_lane_map #(
    .REQ_CREDITS (REQ_CREDITS)
  ) lane_map_i (
    .hclk     (hclk),
    .reset    (reset),
    .up       (req_a.dst),
    .down     (req_b.src),
    .occupied (occupied)
  );

  smc_access_fsm #(
    .WAIT_STATES (WAIT_STATES)
  ) access_fsm_i (
    .hclk         (hclk),
    .reset        (reset),
    .req          (req_b.dst),
    .data_smc     (data_smc),
    .smc_addr     (smc_addr),
    .smc_data     (smc_data),
    .smc_n_be     (smc_n_be),
    .smc_n_cs     (smc_n_cs),
    .smc_n_rd     (smc_n_rd),
    .smc_n_wr     (smc_n_wr),
    .smc_n_ext_oe (smc_n_ext_oe),
    .smc_n_we     (smc_n_we),
    .rdata_valid  (rdata_valid),
    .rdata        (rdata),
    .active       (active)
  );

  assign smc_busy = pending || occupied || active; // Any stage holding work

endmodule
